// ==== filelist.f ====
+incdir+tb
rtl/cpuPkg.sv
rtl/hazardIf.sv
rtl/pipeReg.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/hazardUnit.sv
rtl/retireUnit.sv
rtl/controlDecoder.sv
rtl/datapath.sv
rtl/cpuTop.sv
tb/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the core testbench with Verilator, run it and judge the log
set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --top-module cpuTb -f filelist.f -o cpuTbSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/cpuTbSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$logFile"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail, see $logFile"
exit 1

// ==== tb/tbPrograms.svh ====
`default_nettype none

// one row per program with its words, the expected outputPort and numInst,
// and one data-memory address with the word expected there after the run

localparam int numRows = 6;
localparam int progDepth = 16;
localparam int memDepth = 64;

logic [wordW-1:0] progWords [numRows][progDepth];
logic [wordW-1:0] expOut [numRows];
logic [wordW-1:0] expCount [numRows];
logic [5:0] chkAddr [numRows];
logic [wordW-1:0] expWord [numRows];
int progLen [numRows];
int buildRow;
int buildIdx;

// instruction encoders take operands in assembler order
function automatic logic [wordW-1:0] add(input logic [1:0] rd, rs, rt);
    return {4'd15, rs, rt, rd, 6'd0};
endfunction
function automatic logic [wordW-1:0] sub(input logic [1:0] rd, rs, rt);
    return {4'd15, rs, rt, rd, 6'd1};
endfunction
function automatic logic [wordW-1:0] andRegs(input logic [1:0] rd, rs, rt);
    return {4'd15, rs, rt, rd, 6'd2};
endfunction
function automatic logic [wordW-1:0] orr(input logic [1:0] rd, rs, rt);
    return {4'd15, rs, rt, rd, 6'd3};
endfunction
function automatic logic [wordW-1:0] wwd(input logic [1:0] rs);
    return {4'd15, rs, 2'd0, 2'd0, 6'd28};
endfunction
function automatic logic [wordW-1:0] hlt();
    return {4'd15, 6'd0, 6'd29};
endfunction
function automatic logic [wordW-1:0] adi(input logic [1:0] rt, rs, input logic [7:0] imm);
    return {4'd4, rs, rt, imm};
endfunction
function automatic logic [wordW-1:0] lhi(input logic [1:0] rt, input logic [7:0] imm);
    return {4'd6, 2'd0, rt, imm};
endfunction
function automatic logic [wordW-1:0] lwd(input logic [1:0] rt, rs, input logic [7:0] imm);
    return {4'd7, rs, rt, imm};
endfunction
function automatic logic [wordW-1:0] swd(input logic [1:0] rt, rs, input logic [7:0] imm);
    return {4'd8, rs, rt, imm};
endfunction
function automatic logic [wordW-1:0] bne(input logic [1:0] rs, rt, input logic [7:0] imm);
    return {4'd0, rs, rt, imm};
endfunction
function automatic logic [wordW-1:0] beq(input logic [1:0] rs, rt, input logic [7:0] imm);
    return {4'd1, rs, rt, imm};
endfunction
function automatic logic [wordW-1:0] jmp(input logic [11:0] target);
    return {4'd9, target};
endfunction

// initial data-memory contents differ at every address
function automatic logic [wordW-1:0] dmemFill(input logic [5:0] addr);
    return 16'h5a00 ^ {10'd0, addr};
endfunction

task automatic emit(input logic [wordW-1:0] word);
    progWords[buildRow][buildIdx] = word;
    buildIdx = buildIdx + 1;
endtask

task automatic endRow(input logic [wordW-1:0] outVal, input logic [wordW-1:0] count,
                      input logic [5:0] addr, input logic [wordW-1:0] word);
    expOut[buildRow] = outVal;
    expCount[buildRow] = count;
    chkAddr[buildRow] = addr;
    expWord[buildRow] = word;
    progLen[buildRow] = buildIdx;
    buildRow = buildRow + 1;
    buildIdx = 0;
endtask

task automatic buildTable();
    for (int r = 0; r < numRows; r++) begin
        for (int i = 0; i < progDepth; i++) begin
            progWords[r][i] = '0;
        end
    end
    buildRow = 0;
    buildIdx = 0;
    // dependent ALU chain through both forwarding paths and the bypass
    emit(adi(2'd1, 2'd0, 8'd5));
    emit(adi(2'd2, 2'd1, 8'd3));
    emit(add(2'd3, 2'd1, 2'd2));
    emit(sub(2'd1, 2'd3, 2'd2));
    emit(andRegs(2'd2, 2'd3, 2'd1));
    emit(adi(2'd0, 2'd0, 8'd48));
    emit(orr(2'd3, 2'd0, 2'd2));
    emit(adi(2'd1, 2'd1, 8'd1));
    emit(add(2'd2, 2'd0, 2'd1));
    emit(add(2'd3, 2'd3, 2'd2));
    emit(wwd(2'd3));
    emit(hlt());
    endRow(16'h006b, 16'd12, 6'd0, dmemFill(6'd0));
    // store, load, then a dependent add right behind the load
    emit(adi(2'd1, 2'd0, 8'd10));
    emit(adi(2'd2, 2'd0, 8'hfd));
    emit(swd(2'd2, 2'd1, 8'd2));
    emit(lwd(2'd3, 2'd1, 8'd2));
    emit(add(2'd0, 2'd3, 2'd1));
    emit(swd(2'd0, 2'd1, 8'd3));
    emit(wwd(2'd0));
    emit(hlt());
    endRow(16'h0007, 16'd8, 6'd13, 16'h0007);
    // BNE falls through and BEQ skips two
    emit(adi(2'd1, 2'd0, 8'd7));
    emit(adi(2'd2, 2'd0, 8'd7));
    emit(bne(2'd1, 2'd2, 8'd2));
    emit(adi(2'd3, 2'd0, 8'd1));
    emit(beq(2'd1, 2'd2, 8'd2));
    emit(adi(2'd3, 2'd3, 8'd32));
    emit(wwd(2'd1));
    emit(adi(2'd3, 2'd3, 8'd2));
    emit(wwd(2'd3));
    emit(hlt());
    endRow(16'h0003, 16'd8, 6'd7, dmemFill(6'd7));
    // each JMP skips the next word
    emit(adi(2'd1, 2'd0, 8'd9));
    emit(jmp(12'd3));
    emit(adi(2'd1, 2'd1, 8'd100));
    emit(wwd(2'd1));
    emit(jmp(12'd6));
    emit(wwd(2'd0));
    emit(hlt());
    endRow(16'h0009, 16'd5, 6'd5, dmemFill(6'd5));
    // the stores and the load behind HLT must never reach data memory
    emit(adi(2'd1, 2'd0, 8'd20));
    emit(adi(2'd2, 2'd0, 8'd66));
    emit(wwd(2'd2));
    emit(hlt());
    emit(swd(2'd2, 2'd1, 8'd0));
    emit(swd(2'd1, 2'd1, 8'd0));
    emit(lwd(2'd3, 2'd1, 8'd0));
    endRow(16'h0042, 16'd4, 6'd20, dmemFill(6'd20));
endtask

`default_nettype wire

// ==== tb/cpuTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int resetCycles = 5;
    localparam int haltHold = 10;

    logic Clk = 1'b0;
    logic rstN;
    logic imemRe;
    logic [wordW-1:0] imemAddr;
    logic [wordW-1:0] imemData;
    logic dmemRe;
    logic dmemWe;
    logic [wordW-1:0] dmemAddr;
    logic [wordW-1:0] dmemWdata;
    logic [wordW-1:0] dmemRdata;
    logic halted;
    logic [wordW-1:0] numInst;
    logic [wordW-1:0] outputPort;
    logic memLoad;
    int curRow = 0;
    int seed = 32'h609e_ae3c;

    `include "tbPrograms.svh"

    logic [wordW-1:0] imem [memDepth];
    logic [wordW-1:0] dmem [memDepth];

    always #20 Clk = ~Clk;

    cpuTop cpuTop_inst (
        .Clk(Clk), .rstN(rstN),
        .imemRe(imemRe), .imemAddr(imemAddr), .imemData(imemData),
        .dmemRe(dmemRe), .dmemWe(dmemWe), .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
        .halted(halted), .numInst(numInst), .outputPort(outputPort)
    );

    // both memories answer in the same cycle
    assign imemData = imem[imemAddr[5:0]];
    assign dmemRdata = dmem[dmemAddr[5:0]];

    // program load during reset, otherwise data writes land at the edge
    always @(posedge Clk) begin
        if (memLoad) begin
            for (int i = 0; i < memDepth; i++) begin
                imem[i] <= '0;
                dmem[i] <= dmemFill(6'(i));
            end
            for (int i = 0; i < progDepth; i++) begin
                imem[i] <= progWords[curRow][i];
            end
        end else if (dmemWe) begin
            dmem[dmemAddr[5:0]] <= dmemWdata;
        end
    end

    task automatic abortRun();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first failed check");
    endtask

    task automatic checkValue(input string name, input logic [wordW-1:0] actual,
                              input logic [wordW-1:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s = %h, expected %h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    initial begin
        int maxLen;
        int limit;
        int cycles;
        logic [wordW-1:0] frozenCount;
        logic [7:0] immA;
        logic [7:0] immB;
        logic [7:0] immC;
        logic [7:0] upper;
        logic [wordW-1:0] randSum;

        rstN = 1'b0;
        memLoad = 1'b0;
        buildTable();

        // last row, immediates read as signed 8-bit values
        immA = 8'($random(seed));
        immB = 8'($random(seed));
        immC = 8'($random(seed));
        upper = 8'($random(seed));
        emit(adi(2'd1, 2'd0, immA));
        emit(adi(2'd1, 2'd1, immB));
        emit(adi(2'd1, 2'd1, immC));
        emit(lhi(2'd2, upper));
        emit(add(2'd3, 2'd1, 2'd2));
        emit(wwd(2'd3));
        emit(hlt());
        randSum = {upper, 8'h00} + {{8{immA[7]}}, immA};
        randSum = randSum + {{8{immB[7]}}, immB} + {{8{immC[7]}}, immC};
        endRow(randSum, 16'd7, 6'd63, dmemFill(6'd63));

        maxLen = 0;
        for (int r = 0; r < numRows; r++) begin
            if (progLen[r] > maxLen) begin
                maxLen = progLen[r];
            end
        end
        limit = 4 * maxLen + 20;

        for (int row = 0; row < numRows; row++) begin
            @(posedge Clk);
            #1;
            curRow = row;
            rstN = 1'b0;
            memLoad = 1'b1;
            repeat (resetCycles) begin
                @(posedge Clk);
                #1;
                memLoad = 1'b0;
            end
            checkValue("halted", wordW'(halted), 16'd0);
            checkValue("numInst", numInst, 16'd0);
            checkValue("outputPort", outputPort, 16'd0);
            checkValue("imemRe", wordW'(imemRe), 16'd1);
            checkValue("dmemRe", wordW'(dmemRe), 16'd0);
            checkValue("dmemWe", wordW'(dmemWe), 16'd0);
            rstN = 1'b1;

            cycles = 0;
            while (!halted) begin
                if (cycles >= limit) begin
                    $display("timeout: the core never halted in program %0d after %0d cycles",
                             row, cycles);
                    abortRun();
                end else begin
                    @(posedge Clk);
                    #1;
                    cycles++;
                end
            end

            // once halted nothing retires or touches memory
            frozenCount = numInst;
            repeat (haltHold) begin
                checkValue("halted", wordW'(halted), 16'd1);
                checkValue("numInst", numInst, frozenCount);
                checkValue("imemRe", wordW'(imemRe), 16'd0);
                checkValue("dmemRe", wordW'(dmemRe), 16'd0);
                checkValue("dmemWe", wordW'(dmemWe), 16'd0);
                @(posedge Clk);
                #1;
            end

            checkValue("outputPort", outputPort, expOut[row]);
            checkValue("numInst", numInst, expCount[row]);
            checkValue($sformatf("dmem[%0d]", chkAddr[row]), dmem[chkAddr[row]], expWord[row]);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cpuTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuTop (
    input logic Clk,
    input logic rstN,
    output logic imemRe,
    output logic [cpuPkg::wordW-1:0] imemAddr,
    input logic [cpuPkg::wordW-1:0] imemData,
    output logic dmemRe,
    output logic dmemWe,
    output logic [cpuPkg::wordW-1:0] dmemAddr,
    output logic [cpuPkg::wordW-1:0] dmemWdata,
    input logic [cpuPkg::wordW-1:0] dmemRdata,
    output logic halted,
    output logic [cpuPkg::wordW-1:0] numInst,
    output logic [cpuPkg::wordW-1:0] outputPort
);
    import cpuPkg::*;

    logic [wordW-1:0] ifIdInstr;
    logic ifIdValid;
    ctrlT ctrl;

    // controls are decoded from the instruction sitting in ID
    controlDecoder controlDecoder_inst (
        .instr(ifIdInstr), .valid(ifIdValid), .ctrl(ctrl)
    );

    datapath datapath_inst (
        .Clk(Clk), .rstN(rstN),
        .imemRe(imemRe), .imemAddr(imemAddr), .imemData(imemData),
        .dmemRe(dmemRe), .dmemWe(dmemWe), .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
        .ifIdInstr(ifIdInstr), .ifIdValid(ifIdValid), .ctrl(ctrl),
        .halted(halted), .numInst(numInst), .outputPort(outputPort)
    );

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input logic Clk,
    input logic rstN,
    output logic imemRe,
    output logic [cpuPkg::wordW-1:0] imemAddr,
    input logic [cpuPkg::wordW-1:0] imemData,
    output logic dmemRe,
    output logic dmemWe,
    output logic [cpuPkg::wordW-1:0] dmemAddr,
    output logic [cpuPkg::wordW-1:0] dmemWdata,
    input logic [cpuPkg::wordW-1:0] dmemRdata,
    output logic [cpuPkg::wordW-1:0] ifIdInstr,
    output logic ifIdValid,
    input cpuPkg::ctrlT ctrl,
    output logic halted,
    output logic [cpuPkg::wordW-1:0] numInst,
    output logic [cpuPkg::wordW-1:0] outputPort
);
    import cpuPkg::*;

    logic [wordW-1:0] pc;
    logic [wordW-1:0] pcNext;
    ifIdT ifIdIn, ifId;
    idExT idExIn, idEx;
    exMemT exMemIn, exMem;
    memWbT memWbIn, memWb;
    logic [wordW-1:0] readData1;
    logic [wordW-1:0] readData2;
    logic [wordW-1:0] fwdValA;
    logic [wordW-1:0] fwdValB;
    logic [wordW-1:0] operandB;
    logic [wordW-1:0] aluResult;
    logic aluTaken;
    logic [wordW-1:0] wbData;
    logic regWriteEn;
    logic memStop;

    hazardIf hz ();

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    always_comb begin
        if (halted) begin
            pcNext = pc;
        end else if (hz.branchTaken) begin
            pcNext = idEx.pc + wordW'(1) + idEx.imm;
        end else if (hz.idJump) begin
            pcNext = {ifId.pc[15:12], ifId.instr[11:0]};
        end else if (hz.loadStall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + wordW'(1);
        end
    end

    assign imemRe = !halted;
    assign imemAddr = pc;
    assign ifIdIn = '{valid: 1'b1, pc: pc, instr: imemData};

    pipeReg #(.payloadT(ifIdT)) ifIdReg_inst (
        .Clk(Clk), .rstN(rstN), .hold(hz.loadStall), .bubble(hz.flushId || halted),
        .din(ifIdIn), .dout(ifId)
    );

    // decode
    assign ifIdInstr = ifId.instr;
    assign ifIdValid = ifId.valid;
    assign hz.idRs = ifId.instr[11:10];
    assign hz.idRt = ifId.instr[9:8];
    assign hz.idUseRs = ctrl.useRs;
    assign hz.idUseRt = ctrl.useRt;
    assign hz.idJump = ctrl.isJump;

    regFile regFile_inst (
        .Clk(Clk), .rstN(rstN),
        .readAddr1(ifId.instr[11:10]), .readAddr2(ifId.instr[9:8]),
        .writeAddr(memWb.rd), .writeEn(regWriteEn), .writeData(wbData),
        .readData1(readData1), .readData2(readData2)
    );

    always_comb begin
        idExIn.valid = ifId.valid;
        idExIn.pc = ifId.pc;
        idExIn.ctrl = ctrl;
        idExIn.rs = ifId.instr[11:10];
        idExIn.rt = ifId.instr[9:8];
        idExIn.rd = ctrl.regDstRd ? ifId.instr[7:6] : ifId.instr[9:8];
        idExIn.readData1 = readData1;
        idExIn.readData2 = readData2;
        idExIn.imm = {{(wordW - 8){ifId.instr[7]}}, ifId.instr[7:0]};
    end

    pipeReg #(.payloadT(idExT)) idExReg_inst (
        .Clk(Clk), .rstN(rstN), .hold(1'b0), .bubble(hz.flushEx || hz.loadStall),
        .din(idExIn), .dout(idEx)
    );

    // execute
    assign hz.exRs = idEx.rs;
    assign hz.exRt = idEx.rt;
    assign hz.exRd = idEx.rd;
    assign hz.exMemRead = idEx.ctrl.memRead;
    assign hz.branchTaken = idEx.ctrl.isBranch && aluTaken;

    assign fwdValA = (hz.fwdA == fromExMem) ? exMem.aluResult :
                     (hz.fwdA == fromMemWb) ? wbData : idEx.readData1;
    assign fwdValB = (hz.fwdB == fromExMem) ? exMem.aluResult :
                     (hz.fwdB == fromMemWb) ? wbData : idEx.readData2;

    // LHI is the only passB user and takes the immediate in the upper byte
    always_comb begin
        if (idEx.ctrl.wwd) begin
            operandB = '0;
        end else if (idEx.ctrl.aluSrcImm && idEx.ctrl.aluOp == aluPassB) begin
            operandB = {idEx.imm[7:0], 8'h00};
        end else if (idEx.ctrl.aluSrcImm) begin
            operandB = idEx.imm;
        end else begin
            operandB = fwdValB;
        end
    end

    aluUnit aluUnit_inst (
        .operandA(fwdValA), .operandB(operandB), .aluOp(idEx.ctrl.aluOp),
        .branchEq(idEx.ctrl.branchEq), .result(aluResult), .branchTaken(aluTaken)
    );

    hazardUnit hazardUnit_inst (.hz(hz.unit));

    assign exMemIn = '{valid: idEx.valid, regWrite: idEx.ctrl.regWrite,
                       memToReg: idEx.ctrl.memToReg, memRead: idEx.ctrl.memRead,
                       memWrite: idEx.ctrl.memWrite, wwd: idEx.ctrl.wwd,
                       halt: idEx.ctrl.halt, rd: idEx.rd,
                       aluResult: aluResult, storeData: fwdValB};

    pipeReg #(.payloadT(exMemT)) exMemReg_inst (
        .Clk(Clk), .rstN(rstN), .hold(1'b0), .bubble(1'b0),
        .din(exMemIn), .dout(exMem)
    );

    // memory, nothing behind a retiring HLT touches data memory
    assign memStop = halted || (memWb.valid && memWb.halt);
    assign dmemRe = exMem.valid && exMem.memRead && !memStop;
    assign dmemWe = exMem.valid && exMem.memWrite && !memStop;
    assign dmemAddr = exMem.aluResult;
    assign dmemWdata = exMem.storeData;
    assign hz.memRd = exMem.rd;
    assign hz.memRegWrite = exMem.regWrite;

    assign memWbIn = '{valid: exMem.valid, regWrite: exMem.regWrite,
                       memToReg: exMem.memToReg, wwd: exMem.wwd, halt: exMem.halt,
                       rd: exMem.rd, aluResult: exMem.aluResult, loadData: dmemRdata};

    pipeReg #(.payloadT(memWbT)) memWbReg_inst (
        .Clk(Clk), .rstN(rstN), .hold(1'b0), .bubble(1'b0),
        .din(memWbIn), .dout(memWb)
    );

    // write-back
    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;
    assign regWriteEn = memWb.valid && memWb.regWrite && !halted;
    assign hz.wbRd = memWb.rd;
    assign hz.wbRegWrite = memWb.regWrite;

    retireUnit retireUnit_inst (
        .Clk(Clk), .rstN(rstN),
        .retireValid(memWb.valid), .retireHalt(memWb.halt), .retireWwd(memWb.wwd),
        .retireData(memWb.aluResult),
        .halted(halted), .numInst(numInst), .outputPort(outputPort)
    );

endmodule

`default_nettype wire

// ==== rtl/controlDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
    input logic [cpuPkg::wordW-1:0] instr,
    input logic valid,
    output cpuPkg::ctrlT ctrl
);
    import cpuPkg::*;

    logic [3:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[15:12];
    assign funct = instr[5:0];

    always_comb begin
        ctrl = '0;
        if (valid) begin
            case (opcode)
                opRtype: begin
                    case (funct)
                        fnAdd, fnSub, fnAnd, fnOrr: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.regDstRd = 1'b1;
                            ctrl.useRs = 1'b1;
                            ctrl.useRt = 1'b1;
                            ctrl.aluOp = (funct == fnSub) ? aluSub :
                                         (funct == fnAnd) ? aluAnd :
                                         (funct == fnOrr) ? aluOr : aluAdd;
                        end
                        // rs passes through the adder with a zero operand
                        fnWwd: begin
                            ctrl.wwd = 1'b1;
                            ctrl.useRs = 1'b1;
                        end
                        fnHlt: ctrl.halt = 1'b1;
                        default: ctrl = '0;
                    endcase
                end
                opAdi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.useRs = 1'b1;
                end
                opLhi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.aluOp = aluPassB;
                end
                opLwd: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.useRs = 1'b1;
                end
                opSwd: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.useRs = 1'b1;
                    ctrl.useRt = 1'b1;
                end
                opBne, opBeq: begin
                    ctrl.isBranch = 1'b1;
                    ctrl.branchEq = (opcode == opBeq);
                    ctrl.useRs = 1'b1;
                    ctrl.useRt = 1'b1;
                    ctrl.aluOp = aluSub;
                end
                opJmp: ctrl.isJump = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/retireUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module retireUnit (
    input logic Clk,
    input logic rstN,
    input logic retireValid,
    input logic retireHalt,
    input logic retireWwd,
    input logic [cpuPkg::wordW-1:0] retireData,
    output logic halted,
    output logic [cpuPkg::wordW-1:0] numInst,
    output logic [cpuPkg::wordW-1:0] outputPort
);
    import cpuPkg::*;

    typedef enum logic {
        stRun,
        stHalted
    } stateT;

    stateT state;
    logic retire;

    assign retire = retireValid && state == stRun;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= stRun;
            numInst <= '0;
            outputPort <= '0;
        end else if (retire) begin
            // HLT itself is counted
            numInst <= numInst + wordW'(1);
            if (retireWwd) begin
                outputPort <= retireData;
            end
            if (retireHalt) begin
                state <= stHalted;
            end
        end
    end

    assign halted = (state == stHalted);

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    hazardIf.unit hz
);
    import cpuPkg::*;

    logic rsHit;
    logic rtHit;

    // youngest producer wins
    always_comb begin
        hz.fwdA = fromReg;
        if (hz.memRegWrite && hz.memRd == hz.exRs) begin
            hz.fwdA = fromExMem;
        end else if (hz.wbRegWrite && hz.wbRd == hz.exRs) begin
            hz.fwdA = fromMemWb;
        end
    end

    always_comb begin
        hz.fwdB = fromReg;
        if (hz.memRegWrite && hz.memRd == hz.exRt) begin
            hz.fwdB = fromExMem;
        end else if (hz.wbRegWrite && hz.wbRd == hz.exRt) begin
            hz.fwdB = fromMemWb;
        end
    end

    // a load in EX cannot forward to the instruction right behind it
    assign rsHit = hz.idUseRs && hz.idRs == hz.exRd;
    assign rtHit = hz.idUseRt && hz.idRt == hz.exRd;
    assign hz.loadStall = hz.exMemRead && (rsHit || rtHit);

    assign hz.flushEx = hz.branchTaken;
    assign hz.flushId = hz.branchTaken || hz.idJump;

endmodule

`default_nettype wire

// ==== rtl/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input logic [cpuPkg::wordW-1:0] operandA,
    input logic [cpuPkg::wordW-1:0] operandB,
    input cpuPkg::aluOpT aluOp,
    input logic branchEq,
    output logic [cpuPkg::wordW-1:0] result,
    output logic branchTaken
);
    import cpuPkg::*;

    logic equal;

    always_comb begin
        case (aluOp)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            aluAnd: result = operandA & operandB;
            aluOr: result = operandA | operandB;
            default: result = operandB;
        endcase
    end

    assign equal = (operandA == operandB);

    // BEQ takes on equal, BNE on not equal
    assign branchTaken = branchEq ? equal : !equal;

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input logic Clk,
    input logic rstN,
    input logic [cpuPkg::regAddrW-1:0] readAddr1,
    input logic [cpuPkg::regAddrW-1:0] readAddr2,
    input logic [cpuPkg::regAddrW-1:0] writeAddr,
    input logic writeEn,
    input logic [cpuPkg::wordW-1:0] writeData,
    output logic [cpuPkg::wordW-1:0] readData1,
    output logic [cpuPkg::wordW-1:0] readData2
);
    import cpuPkg::*;

    logic [wordW-1:0] regs [2**regAddrW];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-back value reaches decode in the same cycle
    assign readData1 = (writeEn && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (writeEn && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

// ==== rtl/pipeReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input logic Clk,
    input logic rstN,
    input logic hold,
    input logic bubble,
    input payloadT din,
    output payloadT dout
);

    // all-zero payload is an invalid entry
    always_ff @(posedge Clk) begin
        if (!rstN || bubble) begin
            dout <= '0;
        end else if (!hold) begin
            dout <= din;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hazardIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface hazardIf;
    import cpuPkg::*;

    // decode stage
    logic [regAddrW-1:0] idRs;
    logic [regAddrW-1:0] idRt;
    logic idUseRs;
    logic idUseRt;
    logic idJump;
    // execute stage
    logic [regAddrW-1:0] exRs;
    logic [regAddrW-1:0] exRt;
    logic [regAddrW-1:0] exRd;
    logic exMemRead;
    logic branchTaken;
    // older stages that may write back
    logic [regAddrW-1:0] memRd;
    logic memRegWrite;
    logic [regAddrW-1:0] wbRd;
    logic wbRegWrite;
    // decisions
    fwdSelT fwdA;
    fwdSelT fwdB;
    logic loadStall;
    logic flushId;
    logic flushEx;

    modport pipe (
        output idRs, idRt, idUseRs, idUseRt, idJump,
        output exRs, exRt, exRd, exMemRead, branchTaken,
        output memRd, memRegWrite, wbRd, wbRegWrite,
        input fwdA, fwdB, loadStall, flushId, flushEx
    );

    modport unit (
        input idRs, idRt, idUseRs, idUseRt, idJump,
        input exRs, exRt, exRd, exMemRead, branchTaken,
        input memRd, memRegWrite, wbRd, wbRegWrite,
        output fwdA, fwdB, loadStall, flushId, flushEx
    );

endinterface

`default_nettype wire

// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int wordW = 16;
    localparam int regAddrW = 2;

    // opcodes, bits 15..12
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opRtype = 4'd15;

    // function codes for opRtype, bits 5..0
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        fromReg,
        fromExMem,
        fromMemWb
    } fwdSelT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic isBranch;
        logic branchEq;
        logic aluSrcImm;
        logic isJump;
        logic wwd;
        logic halt;
        logic regDstRd;
        logic useRs;
        logic useRt;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic valid;
        logic [wordW-1:0] pc;
        logic [wordW-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic valid;
        logic [wordW-1:0] pc;
        ctrlT ctrl;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        logic [wordW-1:0] readData1;
        logic [wordW-1:0] readData2;
        logic [wordW-1:0] imm;
    } idExT;

    typedef struct packed {
        logic valid;
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic wwd;
        logic halt;
        logic [regAddrW-1:0] rd;
        logic [wordW-1:0] aluResult;
        logic [wordW-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic valid;
        logic regWrite;
        logic memToReg;
        logic wwd;
        logic halt;
        logic [regAddrW-1:0] rd;
        logic [wordW-1:0] aluResult;
        logic [wordW-1:0] loadData;
    } memWbT;

endpackage

`default_nettype wire
